/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tbMips -f files.f \
		--Mdir obj_dir -o simv

run: compile
	./obj_dir/simv > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "No pass message in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/mipsPipeline.sv
verif/clockGen.sv
verif/tbMemory.sv
verif/tbMips.sv

/* hdl/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            freeze_i,
    input  mipsPkg::wordT   ifInst_i,
    input  mipsPkg::addrT   ifPcPlus4_i,
    input  logic            wbRegWrite_i,
    input  mipsPkg::regIdxT wbRd_i,
    input  mipsPkg::wordT   wbData_i,
    input  mipsPkg::regIdxT memRd_i,
    input  logic            memMemRead_i,
    input  logic            memRegWrite_i,
    input  mipsPkg::wordT   memAluRes_i,
    output logic            exRegWrite_o,
    output logic            exMemRead_o,
    output logic            exMemWrite_o,
    output logic            exAluSrc_o,
    output mipsPkg::aluOpE  exAluOp_o,
    output mipsPkg::regIdxT exRs_o,
    output mipsPkg::regIdxT exRt_o,
    output mipsPkg::regIdxT exRd_o,
    output mipsPkg::wordT   exRsData_o,
    output mipsPkg::wordT   exRtData_o,
    output mipsPkg::wordT   exImm_o,
    output logic            branchTaken_o,
    output mipsPkg::addrT   branchTarget_o,
    output logic            hazardStall_o
);

    mipsPkg::opcodeE opcode;
    mipsPkg::functE  funct;
    mipsPkg::aluOpE  aluOp;
    mipsPkg::regIdxT rs, rt, rd;
    mipsPkg::wordT   imm, rsData, rtData, brRs, brRt;
    mipsPkg::wordT   regs [mipsPkg::NumRegs];
    logic            regWrite, memRead, memWrite, aluSrc, zeroExt, destRt;
    logic            usesRt, isBeq, isBne, loadUse, branchDep;

    assign opcode = mipsPkg::opcodeE'(ifInst_i[31:26]);
    assign funct  = mipsPkg::functE'(ifInst_i[5:0]);
    assign rs     = ifInst_i[25:21];
    assign rt     = ifInst_i[20:16];

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b1;
        zeroExt  = 1'b0;
        destRt   = 1'b1;
        usesRt   = 1'b0;
        isBeq    = 1'b0;
        isBne    = 1'b0;
        aluOp    = mipsPkg::Add;
        case (opcode)
            mipsPkg::RType: begin
                regWrite = 1'b1;
                aluSrc   = 1'b0;
                destRt   = 1'b0;
                usesRt   = 1'b1;
                case (funct)
                    mipsPkg::FnAddu: aluOp = mipsPkg::Add;
                    mipsPkg::FnSubu: aluOp = mipsPkg::Sub;
                    mipsPkg::FnAnd:  aluOp = mipsPkg::And;
                    mipsPkg::FnOr:   aluOp = mipsPkg::Or;
                    mipsPkg::FnSlt:  aluOp = mipsPkg::Slt;
                    mipsPkg::FnSll:  aluOp = mipsPkg::Sll;
                    default:         regWrite = 1'b0;
                endcase
            end
            mipsPkg::Addiu: regWrite = 1'b1;
            mipsPkg::Andi: begin
                regWrite = 1'b1;
                zeroExt  = 1'b1;
                aluOp    = mipsPkg::And;
            end
            mipsPkg::Ori: begin
                regWrite = 1'b1;
                zeroExt  = 1'b1;
                aluOp    = mipsPkg::Or;
            end
            mipsPkg::Slti: begin
                regWrite = 1'b1;
                aluOp    = mipsPkg::Slt;
            end
            mipsPkg::Lw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            mipsPkg::Sw: begin
                memWrite = 1'b1;
                usesRt   = 1'b1;
            end
            mipsPkg::Beq: begin
                isBeq  = 1'b1;
                usesRt = 1'b1;
            end
            mipsPkg::Bne: begin
                isBne  = 1'b1;
                usesRt = 1'b1;
            end
            default: regWrite = 1'b0;
        endcase
    end

    assign rd  = destRt ? rt : ifInst_i[15:11];
    assign imm = zeroExt ? {16'h0000, ifInst_i[15:0]} : {{16{ifInst_i[15]}}, ifInst_i[15:0]};

    always_ff @(posedge clk) begin
        if (wbRegWrite_i && wbRd_i != '0) begin
            regs[wbRd_i] <= wbData_i;
        end
    end

    // Write-before-read bypass, r0 reads zero
    function automatic mipsPkg::wordT readReg(input mipsPkg::regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbRegWrite_i && wbRd_i == idx) begin
            return wbData_i;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rsData = readReg(rs);
        rtData = readReg(rt);
    end

    // Branch compare takes ALU results from MEM, loads are covered by the stall
    assign brRs = (memRegWrite_i && !memMemRead_i && memRd_i == rs) ? memAluRes_i : rsData;
    assign brRt = (memRegWrite_i && !memMemRead_i && memRd_i == rt) ? memAluRes_i : rtData;

    assign loadUse   = exMemRead_o && exRegWrite_o
                       && (exRd_o == rs || (usesRt && exRd_o == rt));
    assign branchDep = (isBeq || isBne)
                       && ((exRegWrite_o && (exRd_o == rs || exRd_o == rt))
                           || (memRegWrite_i && memMemRead_i
                               && (memRd_i == rs || memRd_i == rt)));

    assign hazardStall_o  = loadUse || branchDep;
    assign branchTarget_o = ifPcPlus4_i + {imm[29:0], 2'b00};
    assign branchTaken_o  = !hazardStall_o
                            && ((isBeq && brRs == brRt) || (isBne && brRs != brRt));

    always_ff @(posedge clk) begin
        if (rst) begin
            exRegWrite_o <= 1'b0;
            exMemRead_o  <= 1'b0;
            exMemWrite_o <= 1'b0;
        end else if (!freeze_i) begin
            // Bubble while the hazard holds ID
            exRegWrite_o <= regWrite && rd != '0 && !hazardStall_o;
            exMemRead_o  <= memRead && !hazardStall_o;
            exMemWrite_o <= memWrite && !hazardStall_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            exAluSrc_o <= aluSrc;
            exAluOp_o  <= aluOp;
            exRs_o     <= rs;
            exRt_o     <= rt;
            exRd_o     <= rd;
            exRsData_o <= rsData;
            exRtData_o <= rtData;
            exImm_o    <= imm;
        end
    end

    // Writes to r0 are dropped at decode, so none may arrive from WB
    assert property (@(posedge clk) disable iff (rst) wbRegWrite_i |-> wbRd_i != '0)
        else $error("Register write to r0 reached the register file");

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/10ps

module executeStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            freeze_i,
    input  logic            exRegWrite_i,
    input  logic            exMemRead_i,
    input  logic            exMemWrite_i,
    input  logic            exAluSrc_i,
    input  mipsPkg::aluOpE  exAluOp_i,
    input  mipsPkg::regIdxT exRs_i,
    input  mipsPkg::regIdxT exRt_i,
    input  mipsPkg::regIdxT exRd_i,
    input  mipsPkg::wordT   exRsData_i,
    input  mipsPkg::wordT   exRtData_i,
    input  mipsPkg::wordT   exImm_i,
    input  mipsPkg::regIdxT memRd_i,
    input  logic            memRegWrite_i,
    input  mipsPkg::regIdxT wbRd_i,
    input  logic            wbRegWrite_i,
    input  mipsPkg::wordT   wbData_i,
    output logic            memRegWrite_o,
    output logic            memMemRead_o,
    output logic            memMemWrite_o,
    output mipsPkg::wordT   memAluRes_o,
    output mipsPkg::wordT   memRtData_o,
    output mipsPkg::regIdxT memRd_o
);

    mipsPkg::fwdSelE fwdA, fwdB;
    mipsPkg::wordT   opA, opB, rtFwd, aluRes;
    logic [4:0]      shamt;

    // Newest producer wins
    function automatic mipsPkg::fwdSelE fwdSource(input mipsPkg::regIdxT src);
        if (memRegWrite_i && memRd_i == src) begin
            return mipsPkg::FwdMem;
        end
        if (wbRegWrite_i && wbRd_i == src) begin
            return mipsPkg::FwdWb;
        end
        return mipsPkg::FwdReg;
    endfunction

    always_comb begin
        fwdA = fwdSource(exRs_i);
        fwdB = fwdSource(exRt_i);
        case (fwdA)
            mipsPkg::FwdMem: opA = memAluRes_o;
            mipsPkg::FwdWb:  opA = wbData_i;
            default:         opA = exRsData_i;
        endcase
        case (fwdB)
            mipsPkg::FwdMem: rtFwd = memAluRes_o;
            mipsPkg::FwdWb:  rtFwd = wbData_i;
            default:         rtFwd = exRtData_i;
        endcase
    end

    assign opB   = exAluSrc_i ? exImm_i : rtFwd;
    assign shamt = exImm_i[10:6];

    always_comb begin
        case (exAluOp_i)
            mipsPkg::Add: aluRes = opA + opB;
            mipsPkg::Sub: aluRes = opA - opB;
            mipsPkg::And: aluRes = opA & opB;
            mipsPkg::Or:  aluRes = opA | opB;
            mipsPkg::Slt: aluRes = {31'b0, $signed(opA) < $signed(opB)};
            mipsPkg::Sll: aluRes = opB << shamt;
            default:      aluRes = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memRegWrite_o <= 1'b0;
            memMemRead_o  <= 1'b0;
            memMemWrite_o <= 1'b0;
        end else if (!freeze_i) begin
            memRegWrite_o <= exRegWrite_i;
            memMemRead_o  <= exMemRead_i;
            memMemWrite_o <= exMemWrite_i;
        end
    end

    // Store data is the forwarded rt
    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            memAluRes_o <= aluRes;
            memRtData_o <= rtFwd;
            memRd_o     <= exRd_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(exMemRead_i && exMemWrite_i))
        else $error("Load and store decoded for one instruction");

endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/10ps

module fetchStage #(
    parameter mipsPkg::addrT ResetPc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          freeze_i,
    input  logic          hazardStall_i,
    input  logic          branchTaken_i,
    input  mipsPkg::addrT branchTarget_i,
    input  mipsPkg::wordT imemData_i,
    output mipsPkg::addrT imemAddr_o,
    output mipsPkg::wordT ifInst_o,
    output mipsPkg::addrT ifPcPlus4_o
);

    mipsPkg::addrT pc;
    mipsPkg::addrT pcPlus4;

    assign pcPlus4    = pc + 32'd4;
    assign imemAddr_o = pc;

    // Predict not taken, redirect once decode resolves a taken branch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetPc;
        end else if (!freeze_i && !hazardStall_i) begin
            pc <= branchTaken_i ? branchTarget_i : pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ifInst_o <= '0;
        end else if (!freeze_i) begin
            if (branchTaken_i) begin
                // Squash wrong-path fetch
                ifInst_o <= '0;
            end else if (!hazardStall_i) begin
                ifInst_o <= imemData_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i && !hazardStall_i) begin
            ifPcPlus4_o <= pcPlus4;
        end
    end

    // Branch targets and the reset vector keep the PC on word boundaries
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

/* hdl/memWbStage.sv */
`timescale 1ns/10ps

module memWbStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            freeze_i,
    input  logic            memRegWrite_i,
    input  logic            memMemRead_i,
    input  logic            memMemWrite_i,
    input  mipsPkg::wordT   memAluRes_i,
    input  mipsPkg::wordT   memRtData_i,
    input  mipsPkg::regIdxT memRd_i,
    input  mipsPkg::wordT   dmemRdata_i,
    output logic            dmemRead_o,
    output logic            dmemWrite_o,
    output mipsPkg::addrT   dmemAddr_o,
    output mipsPkg::wordT   dmemWdata_o,
    output logic            wbRegWrite_o,
    output mipsPkg::regIdxT wbRd_o,
    output mipsPkg::wordT   wbData_o
);

    logic          wbMemToReg;
    mipsPkg::wordT wbLoadData;
    mipsPkg::wordT wbAluRes;

    // Request held by EX/MEM until the pipeline advances
    assign dmemRead_o  = memMemRead_i;
    assign dmemWrite_o = memMemWrite_i;
    assign dmemAddr_o  = memAluRes_i;
    assign dmemWdata_o = memRtData_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbRegWrite_o <= 1'b0;
            wbMemToReg   <= 1'b0;
        end else if (!freeze_i) begin
            wbRegWrite_o <= memRegWrite_i;
            wbMemToReg   <= memMemRead_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            wbRd_o     <= memRd_i;
            wbLoadData <= dmemRdata_i;
            wbAluRes   <= memAluRes_i;
        end
    end

    assign wbData_o = wbMemToReg ? wbLoadData : wbAluRes;

endmodule

/* hdl/mipsPipeline.sv */
`timescale 1ns/10ps

module mipsPipeline #(
    parameter mipsPkg::addrT ResetPc = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    output mipsPkg::addrT imemAddr_o,
    input  mipsPkg::wordT imemData_i,
    input  logic          imemReady_i,
    output logic          dmemRead_o,
    output logic          dmemWrite_o,
    output mipsPkg::addrT dmemAddr_o,
    output mipsPkg::wordT dmemWdata_o,
    input  mipsPkg::wordT dmemRdata_i,
    input  logic          dmemReady_i
);

    logic            freeze, hazardStall, branchTaken;
    mipsPkg::addrT   branchTarget, ifPcPlus4;
    mipsPkg::wordT   ifInst;
    logic            exRegWrite, exMemRead, exMemWrite, exAluSrc;
    mipsPkg::aluOpE  exAluOp;
    mipsPkg::regIdxT exRs, exRt, exRd, memRd, wbRd;
    mipsPkg::wordT   exRsData, exRtData, exImm, memAluRes, memRtData, wbData;
    logic            memRegWrite, memMemRead, memMemWrite, wbRegWrite;
    logic            stageRead, stageWrite, dataReq, dataDone;
    mipsPkg::wordT   loadBuf, loadData;

    // An access finished during an instruction-side freeze is not issued again
    assign dmemRead_o  = stageRead && !dataDone;
    assign dmemWrite_o = stageWrite && !dataDone;
    assign dataReq     = dmemRead_o || dmemWrite_o;
    assign freeze      = !imemReady_i || (dataReq && !dmemReady_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            dataDone <= 1'b0;
        end else if (!freeze) begin
            dataDone <= 1'b0;
        end else if (dataReq && dmemReady_i) begin
            dataDone <= 1'b1;
        end
    end

    // Keep load data until MEM/WB can take it
    always_ff @(posedge clk) begin
        if (dmemRead_o && dmemReady_i) begin
            loadBuf <= dmemRdata_i;
        end
    end

    assign loadData = dataDone ? loadBuf : dmemRdata_i;

    fetchStage #(.ResetPc(ResetPc)) fetchStage_inst (
        .clk(clk), .rst(rst), .freeze_i(freeze), .hazardStall_i(hazardStall),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .imemData_i(imemData_i), .imemAddr_o(imemAddr_o),
        .ifInst_o(ifInst), .ifPcPlus4_o(ifPcPlus4)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .rst(rst), .freeze_i(freeze),
        .ifInst_i(ifInst), .ifPcPlus4_i(ifPcPlus4),
        .wbRegWrite_i(wbRegWrite), .wbRd_i(wbRd), .wbData_i(wbData),
        .memRd_i(memRd), .memMemRead_i(memMemRead), .memRegWrite_i(memRegWrite),
        .memAluRes_i(memAluRes),
        .exRegWrite_o(exRegWrite), .exMemRead_o(exMemRead), .exMemWrite_o(exMemWrite),
        .exAluSrc_o(exAluSrc), .exAluOp_o(exAluOp),
        .exRs_o(exRs), .exRt_o(exRt), .exRd_o(exRd),
        .exRsData_o(exRsData), .exRtData_o(exRtData), .exImm_o(exImm),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget),
        .hazardStall_o(hazardStall)
    );

    executeStage executeStage_inst (
        .clk(clk), .rst(rst), .freeze_i(freeze),
        .exRegWrite_i(exRegWrite), .exMemRead_i(exMemRead), .exMemWrite_i(exMemWrite),
        .exAluSrc_i(exAluSrc), .exAluOp_i(exAluOp),
        .exRs_i(exRs), .exRt_i(exRt), .exRd_i(exRd),
        .exRsData_i(exRsData), .exRtData_i(exRtData), .exImm_i(exImm),
        .memRd_i(memRd), .memRegWrite_i(memRegWrite),
        .wbRd_i(wbRd), .wbRegWrite_i(wbRegWrite), .wbData_i(wbData),
        .memRegWrite_o(memRegWrite), .memMemRead_o(memMemRead),
        .memMemWrite_o(memMemWrite), .memAluRes_o(memAluRes),
        .memRtData_o(memRtData), .memRd_o(memRd)
    );

    memWbStage memWbStage_inst (
        .clk(clk), .rst(rst), .freeze_i(freeze),
        .memRegWrite_i(memRegWrite), .memMemRead_i(memMemRead),
        .memMemWrite_i(memMemWrite), .memAluRes_i(memAluRes),
        .memRtData_i(memRtData), .memRd_i(memRd), .dmemRdata_i(loadData),
        .dmemRead_o(stageRead), .dmemWrite_o(stageWrite),
        .dmemAddr_o(dmemAddr_o), .dmemWdata_o(dmemWdata_o),
        .wbRegWrite_o(wbRegWrite), .wbRd_o(wbRd), .wbData_o(wbData)
    );

endmodule

/* hdl/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [4:0]  regIdxT;

    localparam int NumRegs = 32;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        RType = 6'h00,
        Beq   = 6'h04,
        Bne   = 6'h05,
        Addiu = 6'h09,
        Slti  = 6'h0a,
        Andi  = 6'h0c,
        Ori   = 6'h0d,
        Lw    = 6'h23,
        Sw    = 6'h2b
    } opcodeE;

    // R-type funct field, bits 5:0
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnSlt  = 6'h2a
    } functE;

    typedef enum logic [2:0] {
        Add,
        Sub,
        And,
        Or,
        Slt,
        Sll
    } aluOpE;

    // EX operand source
    typedef enum logic [1:0] {
        FwdReg,
        FwdMem,
        FwdWb
    } fwdSelE;

endpackage

/* verif/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
    parameter int Period      = 8,
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the DUT sampling edge
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* verif/tbMemory.sv */
`timescale 1ns/10ps

module tbMemory #(
    parameter mipsPkg::addrT Base = 32'h0000_0100
) (
    input  logic          clk,
    input  logic          randomEn_i,
    input  mipsPkg::addrT imemAddr_i,
    output mipsPkg::wordT imemData_o,
    output logic          imemReady_o,
    input  logic          dmemRead_i,
    input  logic          dmemWrite_i,
    input  mipsPkg::addrT dmemAddr_i,
    input  mipsPkg::wordT dmemWdata_i,
    output mipsPkg::wordT dmemRdata_o,
    output logic          dmemReady_o
);

    localparam int RomWords = 40;
    localparam int RamWords = 64;

    mipsPkg::wordT rom [RomWords];
    mipsPkg::wordT ram [RamWords];
    mipsPkg::addrT romIdx;
    logic          imemRdy = 1'b1;
    logic          dmemRdy = 1'b1;
    integer        seedVar = 63;

    function automatic mipsPkg::wordT rType(input mipsPkg::regIdxT rs, input mipsPkg::regIdxT rt,
                                            input mipsPkg::regIdxT rd, input logic [4:0] shamt,
                                            input mipsPkg::functE fn);
        return {6'h00, rs, rt, rd, shamt, 6'(fn)};
    endfunction

    function automatic mipsPkg::wordT iType(input mipsPkg::opcodeE op, input mipsPkg::regIdxT rs,
                                            input mipsPkg::regIdxT rt, input logic [15:0] imm);
        return {6'(op), rs, rt, imm};
    endfunction

    initial begin
        for (int i = 0; i < RamWords; i++) begin
            // Word address pattern
            ram[i] = 32'hC0DE_0000 | 32'(i * 4);
        end
        for (int i = 0; i < RomWords; i++) begin
            rom[i] = '0;
        end
        rom[0]  = iType(mipsPkg::Addiu, 5'd0, 5'd1, 16'd5);
        rom[1]  = iType(mipsPkg::Addiu, 5'd0, 5'd2, 16'hFFFD);
        rom[2]  = rType(5'd1, 5'd2, 5'd3, 5'd0, mipsPkg::FnAddu);
        rom[3]  = rType(5'd3, 5'd1, 5'd4, 5'd0, mipsPkg::FnSubu);
        rom[4]  = rType(5'd4, 5'd2, 5'd5, 5'd0, mipsPkg::FnAnd);
        rom[5]  = rType(5'd5, 5'd1, 5'd6, 5'd0, mipsPkg::FnOr);
        rom[6]  = rType(5'd2, 5'd1, 5'd7, 5'd0, mipsPkg::FnSlt);
        rom[7]  = rType(5'd0, 5'd6, 5'd8, 5'd4, mipsPkg::FnSll);
        rom[8]  = iType(mipsPkg::Andi, 5'd8, 5'd9, 16'h00F0);
        rom[9]  = iType(mipsPkg::Ori, 5'd9, 5'd10, 16'h1234);
        rom[10] = iType(mipsPkg::Slti, 5'd2, 5'd11, 16'hFFFF);
        rom[11] = iType(mipsPkg::Addiu, 5'd0, 5'd20, 16'h0040);
        rom[12] = iType(mipsPkg::Sw, 5'd20, 5'd3, 16'd0);
        rom[13] = iType(mipsPkg::Sw, 5'd20, 5'd4, 16'd4);
        rom[14] = iType(mipsPkg::Sw, 5'd20, 5'd5, 16'd8);
        rom[15] = iType(mipsPkg::Sw, 5'd20, 5'd6, 16'd12);
        rom[16] = iType(mipsPkg::Sw, 5'd20, 5'd7, 16'd16);
        rom[17] = iType(mipsPkg::Sw, 5'd20, 5'd8, 16'd20);
        rom[18] = iType(mipsPkg::Sw, 5'd20, 5'd10, 16'd24);
        rom[19] = iType(mipsPkg::Sw, 5'd20, 5'd11, 16'd28);
        // Load-use pair
        rom[20] = iType(mipsPkg::Lw, 5'd20, 5'd12, 16'd4);
        rom[21] = rType(5'd12, 5'd1, 5'd13, 5'd0, mipsPkg::FnAddu);
        rom[22] = iType(mipsPkg::Sw, 5'd20, 5'd13, 16'd32);
        rom[23] = iType(mipsPkg::Beq, 5'd1, 5'd1, 16'd1);
        rom[24] = iType(mipsPkg::Sw, 5'd20, 5'd1, 16'd36);
        rom[25] = iType(mipsPkg::Addiu, 5'd0, 5'd14, 16'd7);
        rom[26] = iType(mipsPkg::Bne, 5'd14, 5'd0, 16'd1);
        rom[27] = iType(mipsPkg::Sw, 5'd20, 5'd14, 16'd40);
        rom[28] = iType(mipsPkg::Beq, 5'd14, 5'd1, 16'd1);
        rom[29] = iType(mipsPkg::Sw, 5'd20, 5'd14, 16'd44);
        // Branch on a fresh load, not taken
        rom[30] = iType(mipsPkg::Lw, 5'd20, 5'd15, 16'd0);
        rom[31] = iType(mipsPkg::Bne, 5'd15, 5'd3, 16'd1);
        rom[32] = iType(mipsPkg::Sw, 5'd20, 5'd15, 16'd48);
        rom[33] = rType(5'd15, 5'd14, 5'd16, 5'd0, mipsPkg::FnAddu);
        rom[34] = iType(mipsPkg::Beq, 5'd16, 5'd16, 16'd1);
        rom[35] = iType(mipsPkg::Sw, 5'd20, 5'd16, 16'd52);
        rom[36] = iType(mipsPkg::Sw, 5'd20, 5'd16, 16'd56);
        // Spin here
        rom[37] = iType(mipsPkg::Beq, 5'd0, 5'd0, 16'hFFFF);
    end

    assign romIdx      = (imemAddr_i - Base) >> 2;
    assign imemData_o  = (romIdx < 32'(RomWords)) ? rom[romIdx[5:0]] : '0;
    // Real data only while a load is requested
    assign dmemRdata_o = dmemRead_i ? ram[dmemAddr_i[7:2]] : 32'hDEAD_BEEF;
    assign imemReady_o = imemRdy;
    assign dmemReady_o = dmemRdy;

    always @(posedge clk) begin
        if (dmemWrite_i && dmemRdy) begin
            ram[dmemAddr_i[7:2]] <= dmemWdata_i;
        end
    end

    // Roughly one cycle in four without ready
    always @(negedge clk) begin
        if (randomEn_i) begin
            imemRdy <= ($random(seedVar) % 4) != 0;
            dmemRdy <= ($random(seedVar) % 4) != 0;
        end else begin
            imemRdy <= 1'b1;
            dmemRdy <= 1'b1;
        end
    end

endmodule

/* verif/tbMips.sv */
`timescale 1ns/10ps

module tbMips;

    localparam mipsPkg::addrT ResetPc = 32'h0000_0100;

    logic          clk, rst, runRst, dutRst, randomEn;
    mipsPkg::addrT imemAddr, dmemAddr;
    mipsPkg::wordT imemData, dmemWdata, dmemRdata;
    logic          imemReady, dmemReady, dmemRead, dmemWrite;
    mipsPkg::wordT regModel [mipsPkg::NumRegs];
    mipsPkg::wordT dataModel [mipsPkg::addrT];
    mipsPkg::addrT expAddr [$];
    mipsPkg::wordT expData [$];
    int            storeIdx = 0;
    int            runCycle = 0;

    assign dutRst = rst || runRst;

    clockGen #(.Period(8), .ResetCycles(10)) clockGen_inst (.clk(clk), .rst(rst));

    tbMemory #(.Base(ResetPc)) tbMemory_inst (
        .clk(clk), .randomEn_i(randomEn),
        .imemAddr_i(imemAddr), .imemData_o(imemData), .imemReady_o(imemReady),
        .dmemRead_i(dmemRead), .dmemWrite_i(dmemWrite), .dmemAddr_i(dmemAddr),
        .dmemWdata_i(dmemWdata), .dmemRdata_o(dmemRdata), .dmemReady_o(dmemReady)
    );

    mipsPipeline #(.ResetPc(ResetPc)) mipsPipeline_inst (
        .clk(clk), .rst(dutRst),
        .imemAddr_o(imemAddr), .imemData_i(imemData), .imemReady_i(imemReady),
        .dmemRead_o(dmemRead), .dmemWrite_o(dmemWrite), .dmemAddr_o(dmemAddr),
        .dmemWdata_o(dmemWdata), .dmemRdata_i(dmemRdata), .dmemReady_i(dmemReady)
    );

    task automatic reportError(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic timeoutFail(input string msg);
        $display("Timeout while waiting for %s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on timeout");
    endtask

    // Sequential reference run of the ROM program
    task automatic buildExpected();
        mipsPkg::wordT   inst, a, b, simm, zimm, res;
        mipsPkg::addrT   addr;
        mipsPkg::regIdxT rs, rt, rd;
        logic [5:0]      op, fn;
        int              idx, next, steps;
        logic            stop;
        for (int i = 0; i < mipsPkg::NumRegs; i++) begin
            regModel[i] = '0;
        end
        idx = 0;
        steps = 0;
        stop = 1'b0;
        while (!stop && steps < 500) begin
            inst = tbMemory_inst.rom[idx];
            op   = inst[31:26];
            fn   = inst[5:0];
            rs   = inst[25:21];
            rt   = inst[20:16];
            rd   = inst[15:11];
            a    = regModel[rs];
            b    = regModel[rt];
            simm = {{16{inst[15]}}, inst[15:0]};
            zimm = {16'h0000, inst[15:0]};
            addr = a + simm;
            next = idx + 1;
            case (op)
                mipsPkg::RType: begin
                    case (fn)
                        mipsPkg::FnAddu: res = a + b;
                        mipsPkg::FnSubu: res = a - b;
                        mipsPkg::FnAnd:  res = a & b;
                        mipsPkg::FnOr:   res = a | b;
                        mipsPkg::FnSlt:  res = {31'b0, $signed(a) < $signed(b)};
                        default:         res = b << inst[10:6];
                    endcase
                    if (rd != '0) regModel[rd] = res;
                end
                mipsPkg::Addiu: if (rt != '0) regModel[rt] = a + simm;
                mipsPkg::Andi:  if (rt != '0) regModel[rt] = a & zimm;
                mipsPkg::Ori:   if (rt != '0) regModel[rt] = a | zimm;
                mipsPkg::Slti:  if (rt != '0) regModel[rt] = {31'b0, $signed(a) < $signed(simm)};
                mipsPkg::Lw: begin
                    if (!dataModel.exists(addr)) begin
                        $display("Reference model loads an address never stored");
                    end else if (rt != '0) begin
                        regModel[rt] = dataModel[addr];
                    end
                end
                mipsPkg::Sw: begin
                    dataModel[addr] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                mipsPkg::Beq: if (a == b) next = idx + 1 + int'($signed(simm));
                mipsPkg::Bne: if (a != b) next = idx + 1 + int'($signed(simm));
                default: ;
            endcase
            stop = (next == idx) || (next < 0) || (next >= 40);
            idx = next;
            steps++;
        end
    endtask

    task automatic waitReset(input int limit);
        int cycles;
        cycles = 0;
        while (dutRst) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) timeoutFail("reset release");
        end
    endtask

    task automatic waitStores(input int limit);
        int cycles;
        cycles = 0;
        while (storeIdx < expAddr.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) timeoutFail("the expected stores");
        end
    endtask

    always @(posedge clk) begin
        if (dutRst) begin
            runCycle <= 0;
        end else begin
            runCycle <= runCycle + 1;
        end
    end

    // Completed store against the reference list
    always @(posedge clk) begin
        if (dutRst) begin
            storeIdx <= 0;
        end else if (dmemWrite && dmemReady) begin
            assert (storeIdx < expAddr.size())
                else reportError($sformatf("unexpected store to %h", dmemAddr));
            if (storeIdx < expAddr.size()) begin
                assert (dmemAddr == expAddr[storeIdx] && dmemWdata == expData[storeIdx])
                    else reportError($sformatf("store %0d got %h=%h expected %h=%h",
                                               storeIdx, dmemAddr, dmemWdata,
                                               expAddr[storeIdx], expData[storeIdx]));
            end
            storeIdx <= storeIdx + 1;
        end
    end

    // No data access can reach MEM before the first store does
    always @(posedge clk) begin
        if (!dutRst && runCycle < 15) begin
            assert (!dmemRead && !dmemWrite)
                else reportError("data request before the first memory instruction");
        end
    end

    assert property (@(posedge clk) $fell(dutRst) |-> imemAddr == ResetPc)
        else reportError($sformatf("first fetch at %h", $sampled(imemAddr)));

    assert property (@(posedge clk) dutRst |=> (!dmemRead && !dmemWrite))
        else reportError("data request during reset");

    assert property (@(posedge clk) disable iff (dutRst)
                     (dmemWrite && !dmemReady) |=>
                     (dmemWrite && $stable(dmemAddr) && $stable(dmemWdata)))
        else reportError("store request changed while not ready");

    assert property (@(posedge clk) disable iff (dutRst)
                     (dmemRead && !dmemReady) |=> (dmemRead && $stable(dmemAddr)))
        else reportError("load request changed while not ready");

    assert property (@(posedge clk) disable iff (dutRst) !imemReady |=> $stable(imemAddr))
        else reportError("fetch address changed while not ready");

    initial begin
        runRst   = 1'b0;
        randomEn = 1'b0;

        // Full-speed run
        waitReset(40);
        buildExpected();
        waitStores(400);
        repeat (30) @(negedge clk);

        // Same program with random back-pressure on both ports
        runRst   = 1'b1;
        randomEn = 1'b1;
        repeat (10) @(negedge clk);
        runRst = 1'b0;
        waitStores(3000);
        repeat (60) @(negedge clk);

        $display("=== PASS ===");
        $finish;
    end

endmodule
